//--- rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes, instruction bits [6:0].
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    // One-hot ALU controls.
    typedef struct packed {
        logic arith_sub;
        logic arith_shr;
        logic shift_arithmetical;
        logic res_cmp;            // Result is the compare bit.
        logic res_bits;
        logic res_shift;
        logic bits_xor;
        logic bits_or;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
    } alu_ctrl_t;

    typedef struct packed {
        logic pc;
    } src_op1_t;

    typedef struct packed {
        logic i;                  // I/S/U immediate.
        logic j;                  // Jump immediate.
    } src_op2_t;

    typedef struct packed {
        logic memory;
        logic pc_p4;
    } res_src_t;

    typedef enum logic [2:0] {
        FETCH,
        RS,
        ALU1,
        ALU2,
        ALU3,
        MEM,
        WR
    } core_state_t;

endpackage

//--- rv_bus_pkg.sv
package rv_bus_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic        ready;
        logic [31:0] instruction;
        logic [31:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm_i;       // S immediate for stores.
        logic [31:0] imm_j;       // B immediate for branches.
        alu_ctrl_t   alu_ctrl;
        logic [2:0]  funct3;
        res_src_t    res_src;
        src_op1_t    op1_src;
        src_op2_t    op2_src;
        logic        reg_write;
        logic        inst_jal;
        logic        inst_jalr;
        logic        inst_branch;
        logic        inst_store;
        logic [31:0] pc;
    } decode_bus_t;

    // Classic Wishbone master request.
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } retire_t;

endpackage

//--- rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_fetch_start,
    input  logic                   i_pc_select,
    input  logic [31:0]            i_pc_target,
    input  logic [31:0]            i_instruction,
    input  logic                   i_ack,
    output logic [31:0]            o_addr,
    output logic                   o_cyc,
    output rv_bus_pkg::fetch_bus_t o_bus
);

    logic [31:0] pc;
    logic [31:0] instruction;
    logic        ready;
    logic        boot;          // First fetch after reset.

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pc    <= RESET_ADDR;
            o_cyc <= 1'b0;
            ready <= 1'b0;
            boot  <= 1'b1;
        end
        else
        begin
            boot <= 1'b0;
            if (i_fetch_start)
            begin
                pc    <= i_pc_select ? i_pc_target : pc + 32'd4;
                o_cyc <= 1'b1;
                ready <= 1'b0;
            end
            else if (boot)
                o_cyc <= 1'b1;
            else if (o_cyc && i_ack)
            begin
                o_cyc <= 1'b0;
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_cyc && i_ack)
            instruction <= i_instruction;
    end

    assign o_addr            = pc;
    assign o_bus.ready       = ready;
    assign o_bus.instruction = instruction;
    assign o_bus.pc          = pc;

    // Ready and an open fetch never overlap.
    assert property (@(posedge i_clk) disable iff (!i_reset_n) !(ready && o_cyc));

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  logic                    i_clk,
    input  rv_bus_pkg::fetch_bus_t  i_bus,
    output rv_bus_pkg::decode_bus_t o_bus
);

    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    logic [31:0] inst;
    opcode_t     opcode;
    logic [31:0] imm_i, imm_s, imm_u, imm_b, imm_j;
    decode_bus_t dec;

    function automatic alu_ctrl_t alu_ops(input logic [2:0] f3, input logic sub,
                                          input logic arith);
        alu_ctrl_t c;
        c = '0;
        case (f3)
        3'b000: c.arith_sub = sub;
        3'b001: c.res_shift = 1'b1;
        3'b010: {c.res_cmp, c.cmp_lts} = 2'b11;
        3'b011: {c.res_cmp, c.cmp_ltu} = 2'b11;
        3'b100: {c.res_bits, c.bits_xor} = 2'b11;
        3'b101: {c.res_shift, c.arith_shr, c.shift_arithmetical} = {2'b11, arith};
        3'b110: {c.res_bits, c.bits_or} = 2'b11;
        default: c.res_bits = 1'b1;   // AND.
        endcase
        return c;
    endfunction

    assign inst   = i_bus.instruction;
    assign opcode = opcode_t'(inst[6:0]);
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u  = {inst[31:12], 12'h000};
    assign imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb
    begin
        dec        = '0;
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.rd     = inst[11:7];
        dec.funct3 = inst[14:12];
        dec.imm_i  = imm_i;
        dec.imm_j  = imm_j;
        dec.pc     = i_bus.pc;
        case (opcode)
        LUI:
        begin
            dec.rs1       = 5'd0;       // Zero plus immediate.
            dec.imm_i     = imm_u;
            dec.op2_src.i = 1'b1;
            dec.reg_write = 1'b1;
        end
        AUIPC:
        begin
            dec.imm_i      = imm_u;
            dec.op1_src.pc = 1'b1;
            dec.op2_src.i  = 1'b1;
            dec.reg_write  = 1'b1;
        end
        JAL:
        begin
            dec.op1_src.pc    = 1'b1;
            dec.op2_src.j     = 1'b1;
            dec.res_src.pc_p4 = 1'b1;
            dec.reg_write     = 1'b1;
            dec.inst_jal      = 1'b1;
        end
        JALR:
        begin
            dec.op2_src.i     = 1'b1;
            dec.res_src.pc_p4 = 1'b1;
            dec.reg_write     = 1'b1;
            dec.inst_jalr     = 1'b1;
        end
        BRANCH:
        begin
            dec.imm_j                 = imm_b;
            dec.inst_branch           = 1'b1;
            dec.alu_ctrl.res_cmp      = 1'b1;
            dec.alu_ctrl.cmp_inversed = inst[12];
            dec.alu_ctrl.cmp_lts      = (inst[14:13] == 2'b10);
            dec.alu_ctrl.cmp_ltu      = (inst[14:13] == 2'b11);
        end
        LOAD:
        begin
            dec.op2_src.i      = 1'b1;
            dec.res_src.memory = 1'b1;
            dec.reg_write      = 1'b1;
        end
        STORE:
        begin
            dec.imm_i      = imm_s;
            dec.op2_src.i  = 1'b1;
            dec.inst_store = 1'b1;
        end
        OP_IMM:
        begin
            dec.op2_src.i = 1'b1;
            dec.reg_write = 1'b1;
            dec.alu_ctrl  = alu_ops(inst[14:12], 1'b0, inst[30]);
        end
        OP:
        begin
            dec.reg_write = 1'b1;
            dec.alu_ctrl  = alu_ops(inst[14:12], inst[30], inst[30]);
        end
        default: dec.reg_write = 1'b0;  // Unknown opcode, no effect.
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        o_bus <= dec;
    end

endmodule

//--- rv_regs.sv
`timescale 1ns/1ps

module rv_regs
(
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic [4:0]  i_rs1,
    input  logic [4:0]  i_rs2,
    input  logic [4:0]  i_rd,
    input  logic        i_write,
    input  logic [31:0] i_data,
    output logic [31:0] o_data1,
    output logic [31:0] o_data2
);

    logic [31:0] regs [32];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int r = 0; r < 32; r++)
                regs[r] <= '0;
        end
        else if (i_write)
            regs[i_rd] <= i_data;
    end

    // Registered reads, x0 hardwired to zero.
    always_ff @(posedge i_clk)
    begin
        o_data1 <= (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
        o_data2 <= (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];
    end

    assert property (@(posedge i_clk) disable iff (!i_reset_n) i_write |-> (i_rd != 5'd0));

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    output rv_bus_pkg::wb_req_t o_wb,
    input  logic [31:0]         i_wb_dat,
    input  logic                i_wb_ack,
    output rv_bus_pkg::retire_t o_retire
);

    import rv_isa_pkg::*;
    import rv_bus_pkg::*;

    core_state_t state, state_nxt;
    fetch_bus_t  fetch_bus;
    decode_bus_t decode_bus;
    alu_ctrl_t   ctrl;
    logic [31:0] fetch_addr, rdata1, rdata2, pc_target, write_data;
    logic        fetch_cyc, fetch_ack, bus_data, pc_select, reg_write_en;

    assign bus_data  = (state == ALU3) & (decode_bus.res_src.memory | decode_bus.inst_store);
    assign fetch_ack = i_wb_ack & (state == FETCH);

    always_comb
    begin
        case (state)
        FETCH:   state_nxt = fetch_ack ? RS : FETCH;
        RS:      state_nxt = fetch_bus.ready ? ALU1 : RS;
        ALU1:    state_nxt = ALU2;
        ALU2:    state_nxt = ALU3;
        ALU3:    state_nxt = (!bus_data || i_wb_ack) ? MEM : ALU3;  // Hold until data ack.
        MEM:     state_nxt = WR;
        WR:      state_nxt = FETCH;
        default: state_nxt = FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= FETCH;
        else
            state <= state_nxt;
    end

    rv_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_fetch_start (state == WR),
        .i_pc_select   (pc_select),
        .i_pc_target   (pc_target),
        .i_instruction (i_wb_dat),
        .i_ack         (fetch_ack),
        .o_addr        (fetch_addr),
        .o_cyc         (fetch_cyc),
        .o_bus         (fetch_bus)
    );

    rv_decode u_decode (.i_clk(i_clk), .i_bus(fetch_bus), .o_bus(decode_bus));

    rv_regs u_regs
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_rs1     (decode_bus.rs1),
        .i_rs2     (decode_bus.rs2),
        .i_rd      (decode_bus.rd),
        .i_write   (reg_write_en),
        .i_data    (write_data),
        .o_data1   (rdata1),
        .o_data2   (rdata2)
    );

    // ####################
    // ALU1 and ALU2.
    logic [31:0] pc_branch, op1, op2, op_b, bits, shift;
    logic [32:0] add, shr;
    logic        op_b_sel, overflow, cmp;

    always_ff @(posedge i_clk)
    begin
        pc_branch <= decode_bus.pc + decode_bus.imm_j;    // Register read runs in parallel.
    end

    assign ctrl     = decode_bus.alu_ctrl;
    assign op1      = decode_bus.op1_src.pc ? decode_bus.pc : rdata1;
    assign op2      = decode_bus.op2_src.i ? decode_bus.imm_i :
                      (decode_bus.op2_src.j ? decode_bus.imm_j : rdata2);
    assign op_b_sel = ctrl.arith_sub | ctrl.res_cmp;
    assign op_b     = op_b_sel ? ~op2 : op2;
    assign add      = {1'b0, op1} + {1'b0, op_b} + {32'd0, op_b_sel};   // Shared adder.
    assign overflow = (op1[31] ^ op2[31]) & (op1[31] ^ add[31]);
    assign shr      = $signed({ctrl.shift_arithmetical & op1[31], op1}) >>> op2[4:0];
    assign shift    = ctrl.arith_shr ? shr[31:0] : (op1 << op2[4:0]);

    always_comb
    begin
        case (1'b1)
        ctrl.cmp_lts: cmp = ctrl.cmp_inversed ^ (add[31] ^ overflow);
        ctrl.cmp_ltu: cmp = ctrl.cmp_inversed ^ !add[32];
        default:      cmp = ctrl.cmp_inversed ^ (op1 == op2);
        endcase
        case (1'b1)
        ctrl.bits_xor: bits = op1 ^ op2;
        ctrl.bits_or:  bits = op1 | op2;
        default:       bits = op1 & op2;
        endcase
    end

    // ####################
    // ALU3 and data access.
    logic [31:0] alu3_add, alu3_bits, alu3_shift, alu3_wdata, result, store_data;
    logic [3:0]  sel_mask;
    logic        alu3_cmp, jump;

    always_ff @(posedge i_clk)
    begin
        alu3_add   <= add[31:0];
        alu3_cmp   <= cmp;
        alu3_bits  <= bits;
        alu3_shift <= shift;
        alu3_wdata <= rdata2;
    end

    always_comb
    begin
        case (1'b1)
        ctrl.res_cmp:   result = {31'd0, alu3_cmp};
        ctrl.res_bits:  result = alu3_bits;
        ctrl.res_shift: result = alu3_shift;
        default:        result = alu3_add;
        endcase
        case (decode_bus.funct3[1:0])
        2'b00:   {store_data, sel_mask} = {{4{alu3_wdata[7:0]}}, 4'b0001};
        2'b01:   {store_data, sel_mask} = {{2{alu3_wdata[15:0]}}, 4'b0011};
        default: {store_data, sel_mask} = {alu3_wdata, 4'b1111};
        endcase
    end

    assign jump      = decode_bus.inst_jal | decode_bus.inst_jalr;
    assign pc_select = jump | (decode_bus.inst_branch & alu3_cmp);
    assign pc_target = jump ? {alu3_add[31:1], 1'b0} : pc_branch;

    assign o_wb.adr = bus_data ? alu3_add : fetch_addr;
    assign o_wb.dat = store_data;
    assign o_wb.we  = bus_data & decode_bus.inst_store;
    assign o_wb.sel = bus_data ? (sel_mask << alu3_add[1:0]) : 4'b1111;
    assign o_wb.stb = bus_data | fetch_cyc;
    assign o_wb.cyc = bus_data | fetch_cyc;

    // ####################
    // Load data and writeback.
    logic [31:0] load_word, load_data;
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    always_ff @(posedge i_clk)
    begin
        if (bus_data && i_wb_ack)
            load_word <= i_wb_dat;
    end

    assign load_byte = load_word[{alu3_add[1:0], 3'b000} +: 8];
    assign load_half = load_word[{alu3_add[1], 4'b0000} +: 16];

    always_comb
    begin
        case (decode_bus.funct3)
        3'b000:  load_data = {{24{load_byte[7]}}, load_byte};
        3'b001:  load_data = {{16{load_half[15]}}, load_half};
        3'b100:  load_data = {24'd0, load_byte};
        3'b101:  load_data = {16'd0, load_half};
        default: load_data = load_word;
        endcase
        case (1'b1)
        decode_bus.res_src.memory: write_data = load_data;
        decode_bus.res_src.pc_p4:  write_data = decode_bus.pc + 32'd4;    // Link address.
        default:                   write_data = result;
        endcase
    end

    assign reg_write_en   = (state == WR) & decode_bus.reg_write & (decode_bus.rd != 5'd0);
    assign o_retire.valid = reg_write_en;
    assign o_retire.pc    = decode_bus.pc;
    assign o_retire.rd    = decode_bus.rd;
    assign o_retire.data  = write_data;

    // A store stays in ALU3 with a steady address until it is acknowledged.
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_wb.we && !i_wb_ack) |=> ((state == ALU3) && o_wb.we && $stable(o_wb.adr)));

endmodule

//--- rv_wb_ram.sv
`timescale 1ns/1ps

module rv_wb_ram
#(
    parameter int RAM_WORDS = 1024
)
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  rv_bus_pkg::wb_req_t i_wb,
    output logic [31:0]         o_dat,
    output logic                o_ack,
    input  logic                i_load_valid,
    input  logic [31:0]         i_load_addr,
    input  logic [31:0]         i_load_data
);

    localparam int AW = $clog2(RAM_WORDS);   // Power-of-two depth.

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] wb_index;
    logic          access;

    assign wb_index = i_wb.adr[AW+1:2];
    assign access   = i_wb.cyc & i_wb.stb & !o_ack;   // New request.

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            o_ack <= 1'b0;
        else
            o_ack <= access;
    end

    always_ff @(posedge i_clk)
    begin
        if (access)
        begin
            o_dat <= mem[wb_index];
            if (i_wb.we)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (i_wb.sel[b])
                        mem[wb_index][8*b +: 8] <= i_wb.dat[8*b +: 8];
                end
            end
        end
        if (i_load_valid)
            mem[i_load_addr[AW-1:0]] <= i_load_data;   // Program image.
    end

    // A strobe held past its ack would start a second access.
    assert property (@(posedge i_clk) disable iff (!i_reset_n) o_ack |=> !i_wb.stb);

endmodule

//--- rv_soc.sv
`timescale 1ns/1ps

module rv_soc
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000,
    parameter int          RAM_WORDS  = 1024
)
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_load_valid,
    input  logic [31:0]         i_load_addr,     // Word address.
    input  logic [31:0]         i_load_data,
    output rv_bus_pkg::retire_t o_retire
);

    import rv_bus_pkg::*;

    wb_req_t     wb_req;
    logic [31:0] wb_dat;
    logic        wb_ack;

    rv_core #(.RESET_ADDR(RESET_ADDR)) u_core
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .o_wb      (wb_req),
        .i_wb_dat  (wb_dat),
        .i_wb_ack  (wb_ack),
        .o_retire  (o_retire)
    );

    rv_wb_ram #(.RAM_WORDS(RAM_WORDS)) u_ram
    (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_wb         (wb_req),
        .o_dat        (wb_dat),
        .o_ack        (wb_ack),
        .i_load_valid (i_load_valid),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data)
    );

endmodule

//--- tb_rv_soc.sv
`timescale 1ns/1ps

module tb_rv_soc;

    import rv_bus_pkg::*;

    localparam logic [31:0] RESET_ADDR        = 32'h0000_0100;
    localparam int          RAM_WORDS         = 1024;
    localparam int          DATA_WORDS        = 256;
    localparam int          CYCLES_PER_RECORD = 40;
    localparam int          TAIL_CYCLES       = 40;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        load_valid;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    retire_t     retire;

    logic [31:0] test_data [DATA_WORDS];   // Header, program, count, records.
    int          prog_words;
    int          record_count;
    int          seen_count = 0;
    bit          data_ready = 1'b0;

    rv_soc #(.RESET_ADDR(RESET_ADDR), .RAM_WORDS(RAM_WORDS)) rv_soc_i
    (
        .i_clk        (clk),
        .i_reset_n    (reset_n),
        .i_load_valid (load_valid),
        .i_load_addr  (load_addr),
        .i_load_data  (load_data),
        .o_retire     (retire)
    );

    always #4 clk = ~clk;

    // ####################
    // Failure reporting.
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic compare_retire(input retire_t got, input retire_t exp, input int index);
        if (got.pc !== exp.pc)
            report_mismatch($sformatf("o_retire.pc (record %0d)", index), got.pc, exp.pc);
        else if (got.rd !== exp.rd)
            report_mismatch($sformatf("o_retire.rd (record %0d)", index),
                            {27'd0, got.rd}, {27'd0, exp.rd});
        else if (got.data !== exp.data)
            report_mismatch($sformatf("o_retire.data (record %0d)", index),
                            got.data, exp.data);
    endtask

    task automatic check_no_retire(input retire_t got);
        if (got.valid !== 1'b0)
            report_mismatch("o_retire.valid", {31'd0, got.valid}, 32'd0);
    endtask

    // ####################
    // Retire monitor, sampled mid-cycle.
    always @(negedge clk)
    begin
        retire_t expected;
        int      base;
        if (!reset_n || seen_count >= record_count)
            check_no_retire(retire);             // Reset, or past the last record.
        else if (retire.valid === 1'b1)
        begin
            base           = prog_words + 2 + 3 * seen_count;
            expected.valid = 1'b1;
            expected.pc    = test_data[base];
            expected.rd    = test_data[base + 1][4:0];
            expected.data  = test_data[base + 2];
            compare_retire(retire, expected, seen_count);
            seen_count++;
        end
    end

    // ####################
    // Watchdog.
    initial
    begin
        int limit;
        wait (data_ready);
        // Reset and load, then a fixed budget per record.
        limit = 3 + prog_words + 5 + record_count * CYCLES_PER_RECORD + TAIL_CYCLES;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("Retirement stalled: %0d of %0d records seen after %0d cycles",
                            seen_count, record_count, limit));
    end

    // ####################
    // Load, reset and run.
    initial
    begin
        int seed_value;
        int extra_reset;
        reset_n    = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        seed_value = $urandom(96);

        $readmemh("rv_testdata.hex", test_data);
        prog_words   = int'(test_data[0]);
        record_count = int'(test_data[prog_words + 1]);
        data_ready   = 1'b1;

        repeat (3) @(posedge clk);
        for (int w = 0; w < prog_words; w++)
        begin
            @(posedge clk);
            #1;
            load_valid = 1'b1;
            load_addr  = (RESET_ADDR >> 2) + w;   // Word address.
            load_data  = test_data[w + 1];
        end
        @(posedge clk);
        #1;
        load_valid = 1'b0;

        // A few idle reset cycles before the core starts.
        extra_reset = $urandom % 4;
        repeat (extra_reset) @(posedge clk);
        @(posedge clk);
        #1;
        reset_n = 1'b1;

        wait (seen_count == record_count);
        repeat (TAIL_CYCLES) @(posedge clk);    // Final self loop must stay quiet.
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- rv_testdata.hex
// Program length, program words from RESET_ADDR, record count, then retire records.
// Record columns: pc rd data, all hex.
00000028
00500093 // 100 addi x1, x0, 5
FFD00113 // 104 addi x2, x0, -3
002081B3 // 108 add x3, x1, x2
40208233 // 10c sub x4, x1, x2
001122B3 // 110 slt x5, x2, x1
00113333 // 114 sltu x6, x2, x1
40115393 // 118 srai x7, x2, 1
01C15413 // 11c srli x8, x2, 28
00309493 // 120 slli x9, x1, 3
0F00C513 // 124 xori x10, x1, 0xf0
0020E5B3 // 128 or x11, x1, x2
07F17613 // 12c andi x12, x2, 0x7f
009096B3 // 130 sll x13, x1, x9
12345737 // 134 lui x14, 0x12345
00001797 // 138 auipc x15, 0x1
00708013 // 13c addi x0, x1, 7
00100833 // 140 add x16, x0, x1
70000893 // 144 addi x17, x0, 0x700
89ABD937 // 148 lui x18, 0x89abd
DEF90913 // 14c addi x18, x18, -529
0128A023 // 150 sw x18, 0(x17)
001880A3 // 154 sb x1, 1(x17)
00289323 // 158 sh x2, 6(x17)
0008A983 // 15c lw x19, 0(x17)
00388A03 // 160 lb x20, 3(x17)
0038CA83 // 164 lbu x21, 3(x17)
00689B03 // 168 lh x22, 6(x17)
0068DB83 // 16c lhu x23, 6(x17)
01008463 // 170 beq x1, x16, +8
00100C93 // 174 addi x25, x0, 1
0020C463 // 178 blt x1, x2, +8
FFE12C93 // 17c slti x25, x2, -2
00117463 // 180 bgeu x2, x1, +8
00200C93 // 184 addi x25, x0, 2
00800D6F // 188 jal x26, +8
00300C93 // 18c addi x25, x0, 3
00CD0DE7 // 190 jalr x27, 12(x26)
00400C93 // 194 addi x25, x0, 4
0060BE13 // 198 sltiu x28, x1, 6
0000006F // 19c jal x0, 0
0000001C
00000100 00000001 00000005
00000104 00000002 FFFFFFFD
00000108 00000003 00000002
0000010C 00000004 00000008
00000110 00000005 00000001
00000114 00000006 00000000
00000118 00000007 FFFFFFFE
0000011C 00000008 0000000F
00000120 00000009 00000028
00000124 0000000A 000000F5
00000128 0000000B FFFFFFFD
0000012C 0000000C 0000007D
00000130 0000000D 00000500
00000134 0000000E 12345000
00000138 0000000F 00001138
00000140 00000010 00000005
00000144 00000011 00000700
00000148 00000012 89ABD000
0000014C 00000012 89ABCDEF
0000015C 00000013 89AB05EF
00000160 00000014 FFFFFF89
00000164 00000015 00000089
00000168 00000016 FFFFFFFD
0000016C 00000017 0000FFFD
0000017C 00000019 00000001
00000188 0000001A 0000018C
00000190 0000001B 00000194
00000198 0000001C 00000001

//--- verilog.f
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_core.sv
rv_wb_ram.sv
rv_soc.sv
tb_rv_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_soc -f verilog.f -o tb_rv_soc

sim_output=$(./obj_dir/tb_rv_soc 2>&1) || true
echo "$sim_output"

if grep -Fxq "Simulation finished: PASS" <<< "$sim_output"; then
    exit 0
fi
exit 1
